//--- Makefile
# Verilator build and run for the two-way cache

VERILATOR  ?= verilator
TOP        ?= cache_tb
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
+incdir+logic
logic/cache_msg_pkg.sv
logic/cache_ctrl_pkg.sv
logic/cache_ctrl.sv
logic/cache_tag_array.sv
logic/cache_dpath.sv
logic/cache_top.sv
verification/cache_chk.sv
verification/cache_tb.sv

//--- logic/cache_cfg.svh
// --------------------------------------------------
// Fixed sizes of the two-way cache. One 32-bit word per line
// Changing a width here does not resize the FSM or the LRU scheme
// --------------------------------------------------
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Bus widths
`define CACHE_ADDR_W   32
`define CACHE_DATA_W   32

// Set geometry
`define CACHE_NUM_SETS 8
`define CACHE_INDEX_W  3   // log2 of CACHE_NUM_SETS
`define CACHE_OFFSET_W 2   // Byte offset inside the one-word line

// Address bits left over for the tag
`define CACHE_TAG_W    27

`endif

//--- logic/cache_ctrl.sv
// --------------------------------------------------
// Blocking cache FSM, one request in flight
// Outputs depend on the state only, apart from the request type
// --------------------------------------------------
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                          clk,
  input  logic                          reset,

  input  logic                          cachereq_val,
  output logic                          cachereq_rdy,
  output logic                          cacheresp_val,
  input  logic                          cacheresp_rdy,

  output logic                          memreq_val,
  input  logic                          memreq_rdy,
  input  logic                          memresp_val,
  output logic                          memresp_rdy,

  input  cache_msg_pkg::req_type_e      req_type,
  input  cache_ctrl_pkg::way_status_t   way_status,
  output cache_ctrl_pkg::ctrl_word_t    ctrl
);

  cache_ctrl_pkg::ctrl_state_e state, next_state;

  logic is_write;
  logic is_init;

  assign is_write = (req_type == cache_msg_pkg::REQ_WRITE);
  assign is_init  = (req_type == cache_msg_pkg::REQ_INIT);

  // --------------------------------------------------
  // State register and transitions
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cache_ctrl_pkg::ST_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      cache_ctrl_pkg::ST_IDLE: begin
        if (cachereq_val) next_state = cache_ctrl_pkg::ST_TAG_CHECK;
      end
      cache_ctrl_pkg::ST_TAG_CHECK: begin
        if (is_init) begin
          next_state = cache_ctrl_pkg::ST_INIT_DATA_ACCESS;
        end else if (way_status.hit) begin
          next_state = is_write ? cache_ctrl_pkg::ST_WRITE_DATA_ACCESS
                                : cache_ctrl_pkg::ST_READ_DATA_ACCESS;
        end else if (way_status.victim_dirty) begin
          next_state = cache_ctrl_pkg::ST_EVICT_PREPARE;  // Dirty miss
        end else begin
          next_state = cache_ctrl_pkg::ST_REFILL_REQUEST;
        end
      end
      cache_ctrl_pkg::ST_INIT_DATA_ACCESS,
      cache_ctrl_pkg::ST_READ_DATA_ACCESS,
      cache_ctrl_pkg::ST_WRITE_DATA_ACCESS: next_state = cache_ctrl_pkg::ST_WAIT;
      cache_ctrl_pkg::ST_REFILL_REQUEST: begin
        if (memreq_rdy) next_state = cache_ctrl_pkg::ST_REFILL_WAIT;
      end
      cache_ctrl_pkg::ST_REFILL_WAIT: begin
        if (memresp_val) next_state = cache_ctrl_pkg::ST_REFILL_UPDATE;
      end
      cache_ctrl_pkg::ST_REFILL_UPDATE: begin
        next_state = is_write ? cache_ctrl_pkg::ST_WRITE_DATA_ACCESS
                              : cache_ctrl_pkg::ST_READ_DATA_ACCESS;
      end
      cache_ctrl_pkg::ST_EVICT_PREPARE: next_state = cache_ctrl_pkg::ST_EVICT_REQUEST;
      cache_ctrl_pkg::ST_EVICT_REQUEST: begin
        if (memreq_rdy) next_state = cache_ctrl_pkg::ST_EVICT_WAIT;
      end
      cache_ctrl_pkg::ST_EVICT_WAIT: begin
        if (memresp_val) next_state = cache_ctrl_pkg::ST_REFILL_REQUEST;  // Write ack seen
      end
      cache_ctrl_pkg::ST_WAIT: begin
        if (cacheresp_rdy) next_state = cache_ctrl_pkg::ST_IDLE;
      end
      default: next_state = cache_ctrl_pkg::ST_IDLE;
    endcase
  end

  // --------------------------------------------------
  // Control table
  // --------------------------------------------------

  always_comb begin
    ctrl           = '0;
    ctrl.resp_type = cache_msg_pkg::REQ_NONE;
    cachereq_rdy   = 1'b0;
    cacheresp_val  = 1'b0;
    memreq_val     = 1'b0;
    memresp_rdy    = 1'b0;
    case (state)
      cache_ctrl_pkg::ST_IDLE: begin
        cachereq_rdy = 1'b1;
        ctrl.req_en  = 1'b1;
      end
      cache_ctrl_pkg::ST_TAG_CHECK: begin
        ctrl.way_en  = 1'b1;
        ctrl.lru_wen = 1'b1;
        ctrl.hit_wen = !is_init;    // Init always answers with hit 0
      end
      cache_ctrl_pkg::ST_INIT_DATA_ACCESS: begin
        ctrl.tag_wen   = 1'b1;
        ctrl.valid_in  = 1'b1;
        ctrl.valid_wen = 1'b1;
        ctrl.dirty_wen = 1'b1;      // Line is left clean
        ctrl.data_wen  = 1'b1;
      end
      cache_ctrl_pkg::ST_READ_DATA_ACCESS: ctrl.read_en = 1'b1;
      cache_ctrl_pkg::ST_WRITE_DATA_ACCESS: begin
        ctrl.valid_in  = 1'b1;
        ctrl.valid_wen = 1'b1;
        ctrl.dirty_in  = 1'b1;
        ctrl.dirty_wen = 1'b1;
        ctrl.data_wen  = 1'b1;
      end
      cache_ctrl_pkg::ST_REFILL_REQUEST: memreq_val = 1'b1;
      cache_ctrl_pkg::ST_REFILL_WAIT:    memresp_rdy = 1'b1;
      cache_ctrl_pkg::ST_REFILL_UPDATE: begin
        ctrl.tag_wen   = 1'b1;
        ctrl.valid_in  = 1'b1;
        ctrl.valid_wen = 1'b1;
        ctrl.dirty_wen = 1'b1;
        ctrl.data_wen  = 1'b1;
        ctrl.data_src  = 1'b1;
      end
      cache_ctrl_pkg::ST_EVICT_PREPARE: begin
        ctrl.read_en  = 1'b1;       // Victim data into the read register
        ctrl.evict_en = 1'b1;
      end
      cache_ctrl_pkg::ST_EVICT_REQUEST: begin
        memreq_val      = 1'b1;
        ctrl.memreq_sel = 1'b1;
      end
      cache_ctrl_pkg::ST_EVICT_WAIT: memresp_rdy = 1'b1;
      cache_ctrl_pkg::ST_WAIT: begin
        cacheresp_val  = 1'b1;
        ctrl.resp_type = req_type;
      end
      default: ;
    endcase
  end

endmodule

//--- logic/cache_ctrl_pkg.sv
// --------------------------------------------------
// Control types shared by the FSM, tag array and datapath
// Address fields assume 8 sets of one-word lines
// --------------------------------------------------
`include "cache_cfg.svh"

package cache_ctrl_pkg;

  typedef enum logic [3:0] {
    ST_IDLE              = 4'd0,
    ST_TAG_CHECK         = 4'd1,
    ST_INIT_DATA_ACCESS  = 4'd2,
    ST_READ_DATA_ACCESS  = 4'd3,
    ST_WRITE_DATA_ACCESS = 4'd4,
    ST_REFILL_REQUEST    = 4'd5,
    ST_REFILL_WAIT       = 4'd6,
    ST_REFILL_UPDATE     = 4'd7,
    ST_EVICT_PREPARE     = 4'd8,
    ST_EVICT_REQUEST     = 4'd9,
    ST_EVICT_WAIT        = 4'd10,
    ST_WAIT              = 4'd11
  } ctrl_state_e;

  // Request address seen as a word or as its fields
  typedef union packed {
    logic [`CACHE_ADDR_W-1:0] raw;
    struct packed {
      logic [`CACHE_TAG_W-1:0]    tag;
      logic [`CACHE_INDEX_W-1:0]  index;
      logic [`CACHE_OFFSET_W-1:0] offset;
    } fields;
  } cache_addr_u;

  // Tag lookup result for the current request
  typedef struct packed {
    logic hit;
    logic way;           // Hit way, or the LRU way on a miss
    logic victim_dirty;
  } way_status_t;

  typedef struct packed {
    logic                    req_en;      // Capture request
    logic                    tag_wen;
    logic                    valid_in;
    logic                    valid_wen;
    logic                    dirty_in;
    logic                    dirty_wen;
    logic                    way_en;      // Latch way_used
    logic                    lru_wen;
    logic                    hit_wen;
    logic                    data_wen;
    logic                    data_src;    // 1 selects memory response data
    logic                    read_en;     // Load read-data register
    logic                    evict_en;    // Latch victim address
    logic                    memreq_sel;  // 1 for eviction write
    cache_msg_pkg::req_type_e resp_type;
  } ctrl_word_t;

endpackage

//--- logic/cache_dpath.sv
// --------------------------------------------------
// Request register, data arrays and message forming
// Memory addresses are always word aligned
// --------------------------------------------------
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_dpath (
  input  logic                          clk,
  input  logic                          reset,
  input  cache_msg_pkg::cachereq_msg_t  cachereq_msg,
  input  cache_msg_pkg::memresp_msg_t   memresp_msg,
  input  cache_ctrl_pkg::ctrl_word_t    ctrl,
  input  logic                          way_used,
  input  cache_ctrl_pkg::way_status_t   way_status,
  input  logic [`CACHE_TAG_W-1:0]       victim_tag,
  output cache_msg_pkg::req_type_e      req_type,
  output cache_ctrl_pkg::cache_addr_u   req_addr,
  output cache_msg_pkg::memreq_msg_t    memreq_msg,
  output cache_msg_pkg::cacheresp_msg_t cacheresp_msg
);

  cache_msg_pkg::cachereq_msg_t req_q;

  logic [`CACHE_DATA_W-1:0] data_mem [2][`CACHE_NUM_SETS];
  logic [`CACHE_DATA_W-1:0] memresp_data_q;
  logic [`CACHE_DATA_W-1:0] read_data_q;
  logic [`CACHE_DATA_W-1:0] write_data;
  logic [`CACHE_TAG_W+`CACHE_INDEX_W-1:0] evict_addr_q;  // Victim tag and index
  logic                     hit_q;

  logic [`CACHE_INDEX_W-1:0] idx;

  // --------------------------------------------------
  // Request register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (ctrl.req_en) begin
      req_q <= cachereq_msg;
    end
  end

  assign req_type     = req_q.msg_type;
  assign req_addr.raw = req_q.addr;
  assign idx          = req_addr.fields.index;

  // Sampled every cycle, so in REFILL_UPDATE it holds the word
  // taken on the last REFILL_WAIT edge
  always_ff @(posedge clk) begin
    memresp_data_q <= memresp_msg.data;
  end

  // --------------------------------------------------
  // Data arrays
  // --------------------------------------------------

  assign write_data = ctrl.data_src ? memresp_data_q : req_q.data;

  always_ff @(posedge clk) begin
    if (ctrl.data_wen) begin
      data_mem[way_used][idx] <= write_data;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.read_en) begin
      read_data_q <= data_mem[way_used][idx];   // Read hit or victim word
    end
    if (ctrl.evict_en) begin
      evict_addr_q <= {victim_tag, idx};
    end
  end

  // Hit flag cleared at capture, set in TAG_CHECK
  always_ff @(posedge clk) begin
    if (reset) begin
      hit_q <= 1'b0;
    end else if (ctrl.req_en) begin
      hit_q <= 1'b0;
    end else if (ctrl.hit_wen) begin
      hit_q <= way_status.hit;
    end
  end

  // --------------------------------------------------
  // Outgoing messages
  // --------------------------------------------------

  always_comb begin
    if (ctrl.memreq_sel) begin
      memreq_msg.msg_type = cache_msg_pkg::REQ_WRITE;
      memreq_msg.addr     = {evict_addr_q, {`CACHE_OFFSET_W{1'b0}}};
      memreq_msg.data     = read_data_q;
    end else begin
      memreq_msg.msg_type = cache_msg_pkg::REQ_READ;
      memreq_msg.addr     = {req_addr.fields.tag, idx, {`CACHE_OFFSET_W{1'b0}}};
      memreq_msg.data     = '0;
    end
  end

  assign cacheresp_msg.msg_type = ctrl.resp_type;
  assign cacheresp_msg.hit      = hit_q;
  assign cacheresp_msg.data     = (ctrl.resp_type == cache_msg_pkg::REQ_READ) ? read_data_q
                                                                               : '0;

endmodule

//--- logic/cache_msg_pkg.sv
// --------------------------------------------------
// Requester and memory message formats
// Memory requests reuse the cache request type codes
// --------------------------------------------------
`include "cache_cfg.svh"

package cache_msg_pkg;

  // Same codes on both sides of the cache
  typedef enum logic [3:0] {
    REQ_READ  = 4'd0,
    REQ_WRITE = 4'd1,
    REQ_INIT  = 4'd2,
    REQ_NONE  = 4'd15
  } req_type_e;

  // Requester side
  typedef struct packed {
    req_type_e                msg_type;
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [`CACHE_DATA_W-1:0] data;
  } cachereq_msg_t;             // 68 bits

  typedef struct packed {
    req_type_e                msg_type;
    logic                     hit;
    logic [`CACHE_DATA_W-1:0] data;
  } cacheresp_msg_t;            // 37 bits

  // Memory side
  typedef struct packed {
    req_type_e                msg_type;
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [`CACHE_DATA_W-1:0] data;
  } memreq_msg_t;               // 68 bits

  typedef struct packed {
    req_type_e                msg_type;
    logic [`CACHE_DATA_W-1:0] data;
  } memresp_msg_t;              // 36 bits

endpackage

//--- logic/cache_tag_array.sv
// --------------------------------------------------
// Tag, valid, dirty and LRU state for two ways of 8 sets
// Lookup is combinational from the registered request address
// --------------------------------------------------
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_tag_array (
  input  logic                          clk,
  input  logic                          reset,
  input  cache_ctrl_pkg::cache_addr_u   req_addr,
  input  cache_ctrl_pkg::ctrl_word_t    ctrl,
  output cache_ctrl_pkg::way_status_t   way_status,
  output logic                          way_used,
  output logic [`CACHE_TAG_W-1:0]       victim_tag
);

  logic [`CACHE_TAG_W-1:0]       tags [2][`CACHE_NUM_SETS];
  logic [1:0][`CACHE_NUM_SETS-1:0] valid;
  logic [1:0][`CACHE_NUM_SETS-1:0] dirty;
  logic [`CACHE_NUM_SETS-1:0]    lru;     // Way to replace next

  logic [`CACHE_INDEX_W-1:0] idx;
  logic [1:0]                way_hit;
  logic                      chosen_way;

  assign idx = req_addr.fields.index;

  // --------------------------------------------------
  // Lookup
  // --------------------------------------------------

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = valid[w][idx] && (tags[w][idx] == req_addr.fields.tag);
    end
  end

  always_comb begin
    if (way_hit[0])      chosen_way = 1'b0;
    else if (way_hit[1]) chosen_way = 1'b1;
    else                 chosen_way = lru[idx];
  end

  assign way_status.hit          = |way_hit;
  assign way_status.way          = chosen_way;
  assign way_status.victim_dirty = dirty[chosen_way][idx];

  assign victim_tag = tags[way_used][idx];   // Valid once way_used is latched

  // --------------------------------------------------
  // State update
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid    <= '0;
      dirty    <= '0;
      lru      <= '0;
      way_used <= 1'b0;
    end else begin
      if (ctrl.way_en)    way_used             <= chosen_way;
      if (ctrl.lru_wen)   lru[idx]             <= !chosen_way;
      if (ctrl.valid_wen) valid[way_used][idx] <= ctrl.valid_in;
      if (ctrl.dirty_wen) dirty[way_used][idx] <= ctrl.dirty_in;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.tag_wen) begin
      tags[way_used][idx] <= req_addr.fields.tag;
    end
  end

endmodule

//--- logic/cache_top.sv
// --------------------------------------------------
// Two-way write-back cache, one requester, one memory
// All four ports use val/rdy and transfer when both are high
// --------------------------------------------------
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_top (
  input  logic                          clk,
  input  logic                          reset,

  input  logic                          cachereq_val,
  output logic                          cachereq_rdy,
  input  cache_msg_pkg::cachereq_msg_t  cachereq_msg,

  output logic                          cacheresp_val,
  input  logic                          cacheresp_rdy,
  output cache_msg_pkg::cacheresp_msg_t cacheresp_msg,

  output logic                          memreq_val,
  input  logic                          memreq_rdy,
  output cache_msg_pkg::memreq_msg_t    memreq_msg,

  input  logic                          memresp_val,
  output logic                          memresp_rdy,
  input  cache_msg_pkg::memresp_msg_t   memresp_msg
);

  cache_ctrl_pkg::ctrl_word_t  ctrl;
  cache_ctrl_pkg::way_status_t way_status;
  cache_ctrl_pkg::cache_addr_u req_addr;
  cache_msg_pkg::req_type_e    req_type;
  logic                        way_used;
  logic [`CACHE_TAG_W-1:0]     victim_tag;

  cache_ctrl ctrl0 (
    .clk, .reset,
    .cachereq_val, .cachereq_rdy, .cacheresp_val, .cacheresp_rdy,
    .memreq_val, .memreq_rdy, .memresp_val, .memresp_rdy,
    .req_type, .way_status, .ctrl
  );

  cache_tag_array tags0 (
    .clk, .reset, .req_addr, .ctrl, .way_status, .way_used, .victim_tag
  );

  cache_dpath dpath0 (
    .clk, .reset, .cachereq_msg, .memresp_msg, .ctrl, .way_used, .way_status,
    .victim_tag, .req_type, .req_addr, .memreq_msg, .cacheresp_msg
  );

endmodule

//--- verification/cache_chk.sv
// --------------------------------------------------
// Handshake rules on the cache ports, bound to cache_top
// --------------------------------------------------
`timescale 1ns/1ps

module cache_chk (
  input logic                          clk,
  input logic                          reset,
  input logic                          cachereq_rdy,
  input logic                          cacheresp_val,
  input logic                          cacheresp_rdy,
  input cache_msg_pkg::cacheresp_msg_t cacheresp_msg,
  input logic                          memreq_val,
  input logic                          memreq_rdy,
  input cache_msg_pkg::memreq_msg_t    memreq_msg
);

  int fail_count = 0;   // Read by the testbench at the end of the run

  // Stalled response holds its value
  resp_hold: assert property (@(posedge clk) disable iff (reset)
      (cacheresp_val && !cacheresp_rdy) |=> (cacheresp_val && $stable(cacheresp_msg)))
    else begin
      $error("Response changed or dropped while stalled");
      fail_count++;
    end

  memreq_hold: assert property (@(posedge clk) disable iff (reset)
      (memreq_val && !memreq_rdy) |=> (memreq_val && $stable(memreq_msg)))
    else begin
      $error("Memory request changed or dropped while stalled");
      fail_count++;
    end

  idle_no_resp: assert property (@(posedge clk) disable iff (reset)
      !(cachereq_rdy && cacheresp_val))
    else begin
      $error("Request ready and response valid seen together");
      fail_count++;
    end

endmodule

bind cache_top cache_chk chk0 (
  .clk(clk), .reset(reset), .cachereq_rdy(cachereq_rdy),
  .cacheresp_val(cacheresp_val), .cacheresp_rdy(cacheresp_rdy), .cacheresp_msg(cacheresp_msg),
  .memreq_val(memreq_val), .memreq_rdy(memreq_rdy), .memreq_msg(memreq_msg)
);

//--- verification/cache_tb.sv
// --------------------------------------------------
// Directed and random requests against a reference cache
// Request addresses are word aligned, one request in flight
// --------------------------------------------------
`timescale 1ns/1ps

module cache_tb;

  localparam logic [31:0] SEED = 32'h87ff;
  localparam int DIRECTED_REQS = 8;
  localparam int RANDOM_REQS   = 300;
  localparam int CYCLE_LIMIT   = 200 * (DIRECTED_REQS + RANDOM_REQS);

  logic clk, reset;
  logic cachereq_val, cachereq_rdy, cacheresp_val, cacheresp_rdy;
  logic memreq_val, memreq_rdy, memresp_val, memresp_rdy;
  cache_msg_pkg::cachereq_msg_t  cachereq_msg;
  cache_msg_pkg::cacheresp_msg_t cacheresp_msg;
  cache_msg_pkg::memreq_msg_t    memreq_msg;
  cache_msg_pkg::memresp_msg_t   memresp_msg;

  int cyc = 0;
  int checks, errors, test_checks, test_errors, last_latency;
  string test_name;
  logic bp_on;                  // Random back-pressure on all ports
  logic [31:0] rng_req, rng_mem;

  // Memory model, reference cache and memory-request traces
  logic [31:0] mem [logic [31:0]];
  logic [31:0] ref_mem [logic [31:0]];
  cache_msg_pkg::memreq_msg_t mem_trace[$];
  cache_msg_pkg::memreq_msg_t exp_ops[$];
  logic [26:0] m_tag [2][8];
  logic [31:0] m_data [2][8];
  bit m_valid [2][8];
  bit m_dirty [2][8];
  bit m_lru [8];
  logic [26:0] tag_pool [4] = '{27'h0000010, 27'h0123456, 27'h4abcdef, 27'h7fff001};

  cache_top dut0 (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYCLE_LIMIT) begin
      $display("Timeout: run still busy after %0d cycles", cyc);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] default_word(input logic [31:0] addr);
    return addr ^ 32'h3c5a_9e17;   // Never-written memory words
  endfunction

  // --------------------------------------------------
  // Reporting
  // --------------------------------------------------
  task automatic start_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic finish_test();
    $display("%-12s %0d checks, %0d errors", test_name, test_checks, test_errors);
  endtask

  task automatic check_value(input string what, input logic [67:0] exp, input logic [67:0] got);
    checks++;
    test_checks++;
    assert (got === exp) else begin
      $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, exp, got);
      errors++;
      test_errors++;
    end
  endtask

  // --------------------------------------------------
  // Reference cache that predicts responses and memory traffic
  // --------------------------------------------------
  task automatic model_access(input cache_msg_pkg::req_type_e t, input logic [31:0] addr,
                              input logic [31:0] data, output cache_msg_pkg::cacheresp_msg_t exp);
    logic [2:0] idx;
    logic [26:0] tag;
    logic hit0, hit1, way;
    cache_msg_pkg::memreq_msg_t op;
    idx  = addr[4:2];
    tag  = addr[31:5];
    hit0 = m_valid[0][idx] && (m_tag[0][idx] == tag);
    hit1 = m_valid[1][idx] && (m_tag[1][idx] == tag);
    way  = hit0 ? 1'b0 : (hit1 ? 1'b1 : m_lru[idx]);
    m_lru[idx] = !way;
    exp_ops.delete();
    exp.msg_type = t;
    exp.hit      = 1'b0;
    exp.data     = '0;
    if (t == cache_msg_pkg::REQ_INIT) begin   // Init evicts nothing and leaves the line clean
      m_tag[way][idx]   = tag;
      m_valid[way][idx] = 1'b1;
      m_dirty[way][idx] = 1'b0;
      m_data[way][idx]  = data;
    end else begin
      exp.hit = hit0 || hit1;
      if (!exp.hit) begin
        if (m_dirty[way][idx]) begin
          op = '{cache_msg_pkg::REQ_WRITE, {m_tag[way][idx], idx, 2'b00}, m_data[way][idx]};
          exp_ops.push_back(op);
          ref_mem[op.addr] = op.data;
        end
        op = '{cache_msg_pkg::REQ_READ, {tag, idx, 2'b00}, 32'h0};
        exp_ops.push_back(op);
        m_data[way][idx]  = ref_mem.exists(op.addr) ? ref_mem[op.addr] : default_word(op.addr);
        m_tag[way][idx]   = tag;
        m_valid[way][idx] = 1'b1;
        m_dirty[way][idx] = 1'b0;
      end
      if (t == cache_msg_pkg::REQ_WRITE) begin
        m_data[way][idx]  = data;
        m_dirty[way][idx] = 1'b1;
      end else begin
        exp.data = m_data[way][idx];
      end
    end
  endtask

  // Sends one request through the DUT and checks it against the reference
  task automatic run_request(input cache_msg_pkg::req_type_e t, input logic [31:0] addr,
                             input logic [31:0] data);
    cache_msg_pkg::cacheresp_msg_t exp, got;
    int t_accept, first_val;
    logic taken;
    model_access(t, addr, data, exp);
    mem_trace.delete();
    @(posedge clk);
    #1;
    cachereq_val = 1'b1;
    cachereq_msg = '{t, addr, data};
    @(negedge clk);
    while (!cachereq_rdy) @(negedge clk);
    t_accept = cyc;
    @(posedge clk);
    #1;
    cachereq_val = 1'b0;
    first_val    = -1;
    taken        = 1'b0;
    while (!taken) begin
      rng_req = xorshift(rng_req);
      cacheresp_rdy = bp_on ? rng_req[0] : 1'b1;
      @(negedge clk);
      if (cacheresp_val && first_val < 0) first_val = cyc;
      taken = cacheresp_val && cacheresp_rdy;
      if (!taken) begin
        @(posedge clk);
        #1;
      end
    end
    got = cacheresp_msg;
    last_latency = first_val - t_accept;   // TAG_CHECK counts as cycle 1
    check_value("type", 68'(exp.msg_type), 68'(got.msg_type));
    check_value("hit", 68'(exp.hit), 68'(got.hit));
    check_value("data", 68'(exp.data), 68'(got.data));
    check_value("memory op count", 68'(exp_ops.size()), 68'(mem_trace.size()));
    for (int i = 0; i < exp_ops.size() && i < mem_trace.size(); i++) begin
      check_value("memory op", 68'(exp_ops[i]), 68'(mem_trace[i]));
    end
    @(posedge clk);
    #1;
    cacheresp_rdy = 1'b0;
  endtask

  // --------------------------------------------------
  // Memory model answering one request at a time
  // --------------------------------------------------
  initial begin : memory_model
    cache_msg_pkg::memreq_msg_t req;
    int delay;
    forever begin
      @(posedge clk);
      #1;
      rng_mem = xorshift(rng_mem);
      memreq_rdy = bp_on ? rng_mem[0] : 1'b1;
      @(negedge clk);
      if (memreq_val && memreq_rdy) begin
        req = memreq_msg;
        mem_trace.push_back(req);
        if (req.msg_type == cache_msg_pkg::REQ_WRITE) mem[req.addr] = req.data;
        delay = bp_on ? int'(rng_mem[5:4]) : 0;
        @(posedge clk);
        #1;
        memreq_rdy = 1'b0;
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        memresp_val = 1'b1;
        memresp_msg.msg_type = req.msg_type;
        memresp_msg.data = '0;
        if (req.msg_type == cache_msg_pkg::REQ_READ) begin
          memresp_msg.data = mem.exists(req.addr) ? mem[req.addr] : default_word(req.addr);
        end
        @(negedge clk);
        while (!memresp_rdy) @(negedge clk);
        @(posedge clk);
        #1;
        memresp_val = 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin : main
    logic [31:0] r, a, d;
    cache_msg_pkg::req_type_e t;
    clk = 1'b0;
    reset = 1'b1;
    cachereq_val = 1'b0;
    cachereq_msg = '0;
    cacheresp_rdy = 1'b0;
    memreq_rdy = 1'b0;
    memresp_val = 1'b0;
    memresp_msg = '0;
    bp_on = 1'b0;
    rng_req = SEED;
    rng_mem = SEED ^ 32'h1357_9bdf;
    checks = 0;
    errors = 0;
    repeat (4) @(posedge clk);
    #1 reset = 1'b0;

    start_test("reset_state");
    @(negedge clk);
    check_value("cachereq_rdy", 68'(1), 68'(cachereq_rdy));
    check_value("cacheresp_val", 68'(0), 68'(cacheresp_val));
    check_value("memreq_val", 68'(0), 68'(memreq_val));
    check_value("memresp_rdy", 68'(0), 68'(memresp_rdy));
    run_request(cache_msg_pkg::REQ_READ, 32'h0000_1000, 32'h0);   // Cold miss
    finish_test();

    start_test("hit_timing");
    run_request(cache_msg_pkg::REQ_WRITE, 32'h0000_2004, 32'hcafe_f00d);
    run_request(cache_msg_pkg::REQ_READ, 32'h0000_2004, 32'h0);
    check_value("latency", 68'(3), 68'(last_latency));
    finish_test();

    start_test("init");
    run_request(cache_msg_pkg::REQ_INIT, 32'h0000_3008, 32'h0bad_beef);
    run_request(cache_msg_pkg::REQ_READ, 32'h0000_3008, 32'h0);
    finish_test();

    // Three tags into set 5 make the first one written the victim
    start_test("lru_evict");
    run_request(cache_msg_pkg::REQ_WRITE, {27'h0000100, 3'd5, 2'b00}, 32'h1111_aaaa);
    run_request(cache_msg_pkg::REQ_WRITE, {27'h0000200, 3'd5, 2'b00}, 32'h2222_bbbb);
    run_request(cache_msg_pkg::REQ_WRITE, {27'h0000300, 3'd5, 2'b00}, 32'h3333_cccc);
    if (mem_trace.size() > 0) begin
      check_value("victim write", 68'({cache_msg_pkg::REQ_WRITE, 27'h0000100, 3'd5, 2'b00,
                                        32'h1111_aaaa}), 68'(mem_trace[0]));
    end
    check_value("memory word", 68'(32'h1111_aaaa), 68'(mem[{27'h0000100, 3'd5, 2'b00}]));
    finish_test();

    start_test("random_bp");
    bp_on = 1'b1;
    repeat (RANDOM_REQS) begin
      rng_req = xorshift(rng_req);
      r = rng_req;
      rng_req = xorshift(rng_req);
      d = rng_req;
      a = {tag_pool[r[1:0]], r[4:2], 2'b00};
      if (r[11:8] < 4'd2) t = cache_msg_pkg::REQ_INIT;
      else if (r[11:8] < 4'd9) t = cache_msg_pkg::REQ_WRITE;
      else t = cache_msg_pkg::REQ_READ;
      run_request(t, a, d);
    end
    finish_test();

    if (dut0.chk0.fail_count != 0) begin
      $display("Bound handshake assertions failed %0d times", dut0.chk0.fail_count);
      errors += dut0.chk0.fail_count;
    end
    $display("Total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
